/* design/async_fifo_pkg.sv */
`default_nettype none

package async_fifo_pkg;

    localparam int data_width     = 16;
    localparam int fifo_depth     = 16;
    localparam int pointer_width  = 4;
    localparam int memory_latency = 1;

    typedef logic [data_width-1:0]    data_t;
    typedef logic [pointer_width-1:0] pointer_t;

    typedef struct packed {
        logic     enable;
        pointer_t address;
        data_t    data;
    } ram_write_t;

    typedef struct packed {
        data_t data;
        logic  valid;
    } read_port_t;

    // Output side of the read controller
    typedef enum logic [1:0] {
        stage_idle,
        stage_wait_memory,
        stage_holding
    } read_stage_e;

    function automatic pointer_t binary_to_gray(input pointer_t binary);
        return binary ^ (binary >> 1);
    endfunction

    function automatic pointer_t gray_to_binary(input pointer_t gray);
        pointer_t binary;
        for (int i = 0; i < pointer_width; i++) begin
            binary[i] = ^(gray >> i);
        end
        return binary;
    endfunction

endpackage

`default_nettype wire

/* design/cycle_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module cycle_timer
    import async_fifo_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  logic     load_count,
    input  pointer_t count,
    output logic     expired
);

    pointer_t remaining;

    //////////////////////////////////////////////////////////////////////
    // Down-counter, parks at zero
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            remaining <= '0;
        end
        else if (load_count) begin
            remaining <= count;
        end
        else if (remaining != '0) begin
            remaining <= remaining - pointer_t'(1);
        end
    end

    // Stays high until the next load
    assign expired = (remaining == '0);

endmodule

`default_nettype wire

/* design/dual_clock_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module dual_clock_ram
    import async_fifo_pkg::*;
(
    input  logic       write_clock,
    input  logic       read_clock,
    input  ram_write_t ram_write,
    input  pointer_t   memory_read_address,
    output data_t      memory_read_data
);

    data_t memory [fifo_depth];
    data_t read_pipeline [memory_latency];

    //////////////////////////////////////////////////////////////////////
    // Write port, write clock domain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge write_clock) begin
        if (ram_write.enable) begin
            memory[ram_write.address] <= ram_write.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port, read clock domain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge read_clock) begin
        read_pipeline[0] <= memory[memory_read_address];
        // Extra stages only when the latency asks for them
        for (int i = 1; i < memory_latency; i++) begin
            read_pipeline[i] <= read_pipeline[i-1];
        end
    end

    assign memory_read_data = read_pipeline[memory_latency-1];

endmodule

`default_nettype wire

/* design/async_fifo_write_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module async_fifo_write_controller
    import async_fifo_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       write_enable,
    input  data_t      write_data,
    input  pointer_t   read_pointer_gray,
    output ram_write_t ram_write,
    output pointer_t   write_pointer_gray,
    output logic       full
);

    pointer_t write_pointer;
    pointer_t write_pointer_next;
    pointer_t read_pointer_gray_sync_0;
    pointer_t read_pointer_gray_sync_1;
    pointer_t read_pointer;
    logic     accept;

    //////////////////////////////////////////////////////////////////////
    // Read pointer synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_pointer_gray_sync_0 <= '0;
            read_pointer_gray_sync_1 <= '0;
        end
        else begin
            read_pointer_gray_sync_0 <= read_pointer_gray;
            read_pointer_gray_sync_1 <= read_pointer_gray_sync_0;
        end
    end

    assign read_pointer = gray_to_binary(read_pointer_gray_sync_1);

    //////////////////////////////////////////////////////////////////////
    // Write pointer and full flag
    //////////////////////////////////////////////////////////////////////

    assign accept = write_enable && !full;

    // Depth is a power of two so the pointer wraps on its own
    assign write_pointer_next = accept ? write_pointer + pointer_t'(1) : write_pointer;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer      <= '0;
            write_pointer_gray <= '0;
            full               <= 1'b0;
        end
        else begin
            write_pointer      <= write_pointer_next;
            write_pointer_gray <= binary_to_gray(write_pointer_next);
            // One slot stays free to tell full from empty
            full               <= ((write_pointer_next + pointer_t'(1)) == read_pointer);
        end
    end

    // RAM write lands on the same edge the pointer moves
    assign ram_write.enable  = accept;
    assign ram_write.address = write_pointer;
    assign ram_write.data    = write_data;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // No write into the slot the synchronized read pointer still guards
    full_blocks_ram_write: assert property (
        @(posedge clock) disable iff (!reset_n)
        ram_write.enable |-> ((write_pointer + pointer_t'(1)) != read_pointer)
    );

    gray_single_step: assert property (
        @(posedge clock) disable iff (!reset_n)
        ##1 $countones(write_pointer_gray ^ $past(write_pointer_gray)) <= 1
    );

endmodule

`default_nettype wire

/* design/async_fifo_read_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module async_fifo_read_controller
    import async_fifo_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       read_enable,
    input  pointer_t   write_pointer_gray,
    input  data_t      memory_read_data,
    output read_port_t read_port,
    output pointer_t   memory_read_address,
    output pointer_t   read_pointer_gray,
    output logic       empty
);

    pointer_t    read_pointer;
    pointer_t    read_pointer_next;
    pointer_t    write_pointer_gray_sync_0;
    pointer_t    write_pointer_gray_sync_1;
    pointer_t    write_pointer;
    read_stage_e stage;
    read_stage_e stage_next;
    data_t       read_data;
    logic        capture;
    logic        timer_load;
    logic        timer_expired;

    //////////////////////////////////////////////////////////////////////
    // Memory settle timer
    //////////////////////////////////////////////////////////////////////

    cycle_timer u_memory_timer (
        .clock      (clock),
        .reset_n    (reset_n),
        .load_count (timer_load),
        .count      (pointer_t'(memory_latency)),
        .expired    (timer_expired)
    );

    // Restart on every pointer move, and hold it primed while empty
    assign timer_load = capture || empty;

    //////////////////////////////////////////////////////////////////////
    // Write pointer synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer_gray_sync_0 <= '0;
            write_pointer_gray_sync_1 <= '0;
        end
        else begin
            write_pointer_gray_sync_0 <= write_pointer_gray;
            write_pointer_gray_sync_1 <= write_pointer_gray_sync_0;
        end
    end

    assign write_pointer = gray_to_binary(write_pointer_gray_sync_1);

    //////////////////////////////////////////////////////////////////////
    // Output stage FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stage_next = stage;
        capture    = 1'b0;
        case (stage)
            stage_idle: begin
                if (!empty) begin
                    stage_next = stage_wait_memory;
                end
            end
            stage_wait_memory: begin
                if (timer_expired && !empty) begin
                    capture    = 1'b1;
                    stage_next = stage_holding;
                end
            end
            stage_holding: begin
                if (read_enable) begin
                    stage_next = empty ? stage_idle : stage_wait_memory;
                end
            end
            default: begin
                stage_next = stage_idle;
            end
        endcase
    end

    assign read_pointer_next = capture ? read_pointer + pointer_t'(1) : read_pointer;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            stage             <= stage_idle;
            read_pointer      <= '0;
            read_pointer_gray <= '0;
            empty             <= 1'b1;
        end
        else begin
            stage             <= stage_next;
            read_pointer      <= read_pointer_next;
            read_pointer_gray <= binary_to_gray(read_pointer_next);
            // Compared against the pointer that will be in place next cycle
            empty             <= (write_pointer == read_pointer_next);
        end
    end

    // Held word
    always_ff @(posedge clock) begin
        if (capture) begin
            read_data <= memory_read_data;
        end
    end

    assign memory_read_address = read_pointer;
    assign read_port.data      = read_data;
    assign read_port.valid     = (stage == stage_holding);

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    held_word_stable: assert property (
        @(posedge clock) disable iff (!reset_n)
        read_port.valid && !read_enable |=> read_port.valid && $stable(read_port.data)
    );

    // Captured slot must lie behind the synchronized write pointer
    no_valid_from_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(read_port.valid) |-> $past(write_pointer != read_pointer)
    );

endmodule

`default_nettype wire

/* design/async_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module async_fifo
    import async_fifo_pkg::*;
(
    input  logic       write_clock,
    input  logic       read_clock,
    input  logic       reset_n,
    input  logic       write_enable,
    input  data_t      write_data,
    output logic       full,
    input  logic       read_enable,
    output read_port_t read_port,
    output logic       empty
);

    ram_write_t ram_write;
    pointer_t   write_pointer_gray;
    pointer_t   read_pointer_gray;
    pointer_t   memory_read_address;
    data_t      memory_read_data;

    //////////////////////////////////////////////////////////////////////
    // Write clock domain
    //////////////////////////////////////////////////////////////////////

    async_fifo_write_controller u_write_controller (
        .clock              (write_clock),
        .reset_n            (reset_n),
        .write_enable       (write_enable),
        .write_data         (write_data),
        .read_pointer_gray  (read_pointer_gray),
        .ram_write          (ram_write),
        .write_pointer_gray (write_pointer_gray),
        .full               (full)
    );

    // Storage straddles both domains
    dual_clock_ram u_ram (
        .write_clock         (write_clock),
        .read_clock          (read_clock),
        .ram_write           (ram_write),
        .memory_read_address (memory_read_address),
        .memory_read_data    (memory_read_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Read clock domain
    //////////////////////////////////////////////////////////////////////

    async_fifo_read_controller u_read_controller (
        .clock               (read_clock),
        .reset_n             (reset_n),
        .read_enable         (read_enable),
        .write_pointer_gray  (write_pointer_gray),
        .memory_read_data    (memory_read_data),
        .read_port           (read_port),
        .memory_read_address (memory_read_address),
        .read_pointer_gray   (read_pointer_gray),
        .empty               (empty)
    );

endmodule

`default_nettype wire

/* bench/async_fifo_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module async_fifo_tb
    import async_fifo_pkg::*;
();

    localparam string stimulus_path            = "bench/async_fifo_stimulus.txt";
    localparam int    watchdog_cycles_per_line = 200;

    logic       write_clock;
    logic       read_clock;
    logic       reset_n;
    logic       write_enable;
    data_t      write_data;
    logic       full;
    logic       read_enable;
    read_port_t read_port;
    logic       empty;

    data_t       expected_words [$];
    int unsigned watchdog_cycles = 0;

    async_fifo u_async_fifo (
        .write_clock  (write_clock),
        .read_clock   (read_clock),
        .reset_n      (reset_n),
        .write_enable (write_enable),
        .write_data   (write_data),
        .full         (full),
        .read_enable  (read_enable),
        .read_port    (read_port),
        .empty        (empty)
    );

    //////////////////////////////////////////////////////////////////////
    // Clocks, read side offset by 7 ns
    //////////////////////////////////////////////////////////////////////

    initial begin
        write_clock = 1'b0;
        forever #10 write_clock = ~write_clock;
    end

    initial begin
        read_clock = 1'b0;
        #7;
        forever #10 read_clock = ~read_clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Write and read side drivers
    //////////////////////////////////////////////////////////////////////

    // Accepted only if full is low at the edge
    task automatic write_word(input data_t word, output logic accepted);
        @(negedge write_clock);
        repeat ($urandom_range(0, 2)) @(negedge write_clock);
        accepted     = !full;
        write_enable = 1'b1;
        write_data   = word;
        @(negedge write_clock);
        write_enable = 1'b0;
        if (accepted) begin
            expected_words.push_back(word);
        end
    endtask

    // Words dropped while full are lost
    task automatic write_burst(input data_t base, input int count);
        logic accepted;
        for (int i = 0; i < count; i++) begin
            write_word(base + data_t'(i), accepted);
        end
    endtask

    // Retries each word until it lands
    task automatic stream_words(input data_t base, input int count);
        logic accepted;
        for (int i = 0; i < count; i++) begin
            accepted = 1'b0;
            while (!accepted) begin
                write_word(base + data_t'(i), accepted);
            end
        end
    endtask

    task automatic read_words(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge read_clock);
            repeat ($urandom_range(0, 3)) @(negedge read_clock);
            while (!read_port.valid) begin
                @(negedge read_clock);
            end
            if (expected_words.size() == 0) begin
                $display("Read side presented a word that was never written");
                abort_run();
            end
            check_word("read_port.data", expected_words[0], read_port.data);
            read_enable = 1'b1;
            @(negedge read_clock);
            read_enable = 1'b0;
            void'(expected_words.pop_front());
        end
    endtask

    // Held word must not move while read_enable is low
    task automatic hold_check(input int cycles);
        if (expected_words.size() == 0) begin
            $display("Hold check requested with no word outstanding");
            abort_run();
        end
        repeat (cycles) begin
            @(negedge read_clock);
            check_flag("read_port.valid", 1'b1, read_port.valid);
            check_word("read_port.data", expected_words[0], read_port.data);
        end
    endtask

    task automatic expect_flag(input byte flag_name, input logic value);
        case (flag_name)
            "e": begin
                @(negedge read_clock);
                check_flag("empty", value, empty);
            end
            "f": begin
                @(negedge write_clock);
                check_flag("full", value, full);
            end
            "v": begin
                @(negedge read_clock);
                check_flag("read_port.valid", value, read_port.valid);
            end
            default: begin
                $display("Unknown flag %c in stimulus file", flag_name);
                abort_run();
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus file interpreter
    //////////////////////////////////////////////////////////////////////

    function automatic int count_stimulus_lines();
        int    fd;
        int    lines;
        string text_line;
        lines = 0;
        fd = $fopen(stimulus_path, "r");
        if (fd != 0) begin
            while ($fgets(text_line, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
        return lines;
    endfunction

    task automatic run_stimulus();
        int          fd;
        int          fields;
        string       text_line;
        byte         opcode;
        byte         flag_name;
        int unsigned first;
        int unsigned second;
        fd = $fopen(stimulus_path, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", stimulus_path);
            abort_run();
        end
        while (!$feof(fd)) begin
            text_line = "";
            void'($fgets(text_line, fd));
            fields = $sscanf(text_line, "%c", opcode);
            if (fields < 1 || opcode == "#" || opcode == "\n") begin
                continue;
            end
            case (opcode)
                "W": begin
                    fields = $sscanf(text_line, "%c %h %d", opcode, first, second);
                    write_burst(data_t'(first), second);
                end
                "M": begin
                    fields = $sscanf(text_line, "%c %h %d", opcode, first, second);
                    fork
                        stream_words(data_t'(first), second);
                        read_words(second);
                    join
                end
                "R": begin
                    fields = $sscanf(text_line, "%c %d", opcode, first);
                    read_words(first);
                end
                "D": begin
                    fields = $sscanf(text_line, "%c %d", opcode, first);
                    repeat (first) @(negedge write_clock);
                end
                "H": begin
                    fields = $sscanf(text_line, "%c %d", opcode, first);
                    hold_check(first);
                end
                "E": begin
                    fields = $sscanf(text_line, "%c %c %d", opcode, flag_name, second);
                    expect_flag(flag_name, second[0]);
                end
                default: begin
                    $display("Unknown operation %c in stimulus file", opcode);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_n      = 1'b0;
        write_enable = 1'b0;
        write_data   = '0;
        read_enable  = 1'b0;
        void'($urandom(32'h230e));
        watchdog_cycles = count_stimulus_lines() * watchdog_cycles_per_line;
        repeat (4) @(negedge write_clock);
        reset_n = 1'b1;
        run_stimulus();
        if (expected_words.size() != 0) begin
            $display("%0d written words were never read back", expected_words.size());
            abort_run();
        end
        else begin
            $display("Verification passed");
            $finish;
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge write_clock);
        $display("Run hung with no end after %0d write clock cycles", watchdog_cycles);
        abort_run();
    end

endmodule

`default_nettype wire

/* async_fifo.f */
design/async_fifo_pkg.sv
design/cycle_timer.sv
design/dual_clock_ram.sv
design/async_fifo_write_controller.sv
design/async_fifo_read_controller.sv
design/async_fifo.sv
bench/async_fifo_tb.sv

/* Bender.yml */
package:
  name: async_fifo

sources:
  - design/async_fifo_pkg.sv
  - design/cycle_timer.sv
  - design/dual_clock_ram.sv
  - design/async_fifo_write_controller.sv
  - design/async_fifo_read_controller.sv
  - design/async_fifo.sv
  - target: simulation
    files:
      - bench/async_fifo_tb.sv

/* bench/async_fifo_stimulus.txt */
# op arg1 arg2: W base count writes words upward from base, M base count mixes
# R count reads, D cycles waits, H cycles holds, E flag value checks e f v
E e 1
E f 0
E v 0
W 1a01 4
D 10
E v 1
E e 0
R 4
D 10
E e 1
E v 0
W 2b00 16
D 10
E f 1
W dead 1
E f 1
H 20
R 16
D 10
E e 1
E v 0
E f 0
M 3c00 120
D 10
E e 1
